// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = can_decoder_tb
FILELIST  = verilog.f
BUILD_DIR = obj_dir
LOG       = sim.log
RUN_FLAGS = +verilator+error+limit+100

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, search the log for the pass line"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) $(RUN_FLAGS) | tee $(LOG)
	@grep -q "^RESULT: PASS$$" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== hdl/can_bit_if.sv ====
`timescale 1ns/1ps

// Sampled bit stream from the destuffer to the frame decoder
interface can_bit_if;

	logic sample;		// One strobe per bus bit
	logic bit_value;	// Sampled level, 0 is dominant
	logic stuff_bit;	// Current bit is a stuff bit, skip it
	logic stuff_error;	// Current bit breaks the stuffing rule
	logic stuff_active;	// Decoder is inside a stuffed field

	modport destuffer (
		output sample, bit_value, stuff_bit, stuff_error,
		input  stuff_active
	);

	modport decoder (
		input  sample, bit_value, stuff_bit, stuff_error,
		output stuff_active
	);

endinterface

// ==== hdl/can_bus_pkg.sv ====
package can_bus_pkg;

	//==============================
	// Field lengths in bus bits
	//==============================
	localparam int len_id_a         = 11;	// Base identifier
	localparam int len_id_b         = 18;	// Identifier extension
	localparam int len_dlc          = 4;	// Data length code
	localparam int len_crc          = 15;	// CRC sequence and register
	localparam int len_eof          = 7;	// Recessive end of frame
	localparam int len_intermission = 2;	// Recessive bits before idle

	//==============================
	// Bit stuffing and CRC
	//==============================

	// Five equal bits force an opposite stuff bit
	localparam int stuff_run = 5;

	// x^15 + x^14 + x^10 + x^8 + x^7 + x^4 + x^3 + 1
	localparam logic [len_crc-1:0] crc_poly = 15'h4599;

	// DLC values above this still carry eight bytes
	localparam int max_data_bytes = 8;

endpackage

// ==== hdl/can_crc15.sv ====
`timescale 1ns/1ps

module can_crc15 (
	input  logic                           clock,
	input  logic                           reset,
	input  logic                           crc_init,	// Start of frame
	input  logic                           crc_shift,	// One destuffed bit
	input  logic                           crc_bit,
	output logic [can_bus_pkg::len_crc-1:0] crc_value
);

	import can_bus_pkg::*;

	logic feedback;

	// Incoming bit against the register MSB
	assign feedback = crc_bit ^ crc_value[len_crc-1];

	// Serial LFSR, one step per covered bit
	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
			crc_value <= '0;
		else if (crc_init)
			crc_value <= '0;	// SOF is dominant, so shifting it leaves zero
		else if (crc_shift)
			crc_value <= {crc_value[len_crc-2:0], 1'b0} ^ (crc_poly & {len_crc{feedback}});
	end

endmodule

// ==== hdl/can_decoder.sv ====
`timescale 1ns/1ps

module can_decoder #(
	parameter int bus_idle_bits = 11	// Recessive run that ends error recovery
) (
	input  logic                                   clock,
	input  logic                                   reset,
	input  logic                                   rx_bit,
	input  logic                                   sample_point,
	output logic                                   frame_valid,
	output logic                                   frame_error,
	output can_frame_pkg::error_kind_t             error_kind,
	output logic [can_frame_pkg::frame_id_w-1:0]   frame_id,
	output logic                                   frame_ide,
	output logic                                   frame_rtr,
	output logic [can_bus_pkg::len_dlc-1:0]        frame_dlc,
	output logic [can_frame_pkg::frame_data_w-1:0] frame_data
);

	import can_bus_pkg::*;

	logic               crc_init;
	logic               crc_shift;
	logic               crc_bit;
	logic [len_crc-1:0] crc_value;

	// Destuffed bit stream
	can_bit_if u_bits ();

	can_destuffer u_destuffer (
		.clock        (clock),
		.reset        (reset),
		.rx_bit       (rx_bit),
		.sample_point (sample_point),
		.bits         (u_bits.destuffer)
	);

	can_crc15 u_crc (
		.clock     (clock),
		.reset     (reset),
		.crc_init  (crc_init),
		.crc_shift (crc_shift),
		.crc_bit   (crc_bit),
		.crc_value (crc_value)
	);

	can_frame_fsm #(
		.bus_idle_bits (bus_idle_bits)
	) u_fsm (
		.clock       (clock),
		.reset       (reset),
		.bits        (u_bits.decoder),
		.crc_value   (crc_value),
		.crc_init    (crc_init),
		.crc_shift   (crc_shift),
		.crc_bit     (crc_bit),
		.frame_valid (frame_valid),
		.frame_error (frame_error),
		.error_kind  (error_kind),
		.frame_id    (frame_id),
		.frame_ide   (frame_ide),
		.frame_rtr   (frame_rtr),
		.frame_dlc   (frame_dlc),
		.frame_data  (frame_data)
	);

endmodule

// ==== hdl/can_destuffer.sv ====
`timescale 1ns/1ps

module can_destuffer (
	input  logic clock,
	input  logic reset,
	input  logic rx_bit,
	input  logic sample_point,
	can_bit_if.destuffer bits
);

	import can_bus_pkg::*;

	// Alternating start so no run is seen right after reset
	localparam logic [stuff_run-1:0] hist_init = stuff_run'(32'h5555_5555);

	logic [stuff_run-1:0] history;	// Last sampled bits, newest in bit 0
	logic run_low;
	logic run_high;

	assign run_low  = (history == '0);	// Five dominant in a row
	assign run_high = &history;			// Five recessive in a row

	// History includes SOF and stuff bits, as the bus counts them
	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
			history <= hist_init;
		else if (sample_point)
			history <= {history[stuff_run-2:0], rx_bit};
	end

	//==============================
	// Stream to the decoder
	//==============================
	assign bits.sample    = sample_point;
	assign bits.bit_value = rx_bit;

	// Opposite bit after a run is inserted by the sender
	assign bits.stuff_bit = bits.stuff_active &
		((run_low & rx_bit) | (run_high & ~rx_bit));

	// Same bit again means the stuff bit is missing
	assign bits.stuff_error = bits.stuff_active &
		((run_low & ~rx_bit) | (run_high & rx_bit));

endmodule

// ==== hdl/can_frame_fsm.sv ====
`timescale 1ns/1ps

module can_frame_fsm #(
	parameter int bus_idle_bits = 11
) (
	input  logic                                 clock,
	input  logic                                 reset,
	can_bit_if.decoder                           bits,
	input  logic [can_bus_pkg::len_crc-1:0]      crc_value,
	output logic                                 crc_init,
	output logic                                 crc_shift,
	output logic                                 crc_bit,
	output logic                                 frame_valid,
	output logic                                 frame_error,
	output can_frame_pkg::error_kind_t           error_kind,
	output logic [can_frame_pkg::frame_id_w-1:0] frame_id,
	output logic                                 frame_ide,
	output logic                                 frame_rtr,
	output logic [can_bus_pkg::len_dlc-1:0]      frame_dlc,
	output logic [can_frame_pkg::frame_data_w-1:0] frame_data
);

	import can_bus_pkg::*;
	import can_frame_pkg::*;

	// Wide enough for 64 data bits and for the idle run
	localparam int data_cnt_w = $clog2(frame_data_w + 1);
	localparam int idle_cnt_w = $clog2(bus_idle_bits + 1);
	localparam int cnt_w      = (idle_cnt_w > data_cnt_w) ? idle_cnt_w : data_cnt_w;

	decoder_state_t state;
	decoder_state_t state_next;
	error_kind_t    err_next;
	logic           valid_next;
	logic [cnt_w-1:0] cnt;			// Bits in current state
	logic [cnt_w-1:0] data_last;	// Last data bit index
	logic [len_crc-1:0] crc_rx;		// Received CRC sequence
	logic [len_dlc-1:0] dlc_in;
	logic [len_dlc-1:0] dlc_clip;
	logic rx_bit;
	logic take_bit;					// Real frame bit on this strobe

	assign rx_bit    = bits.bit_value;
	assign take_bit  = bits.sample & ~bits.stuff_bit;
	assign dlc_in    = {frame_dlc[len_dlc-2:0], rx_bit};
	assign dlc_clip  = (dlc_in > len_dlc'(max_data_bytes)) ? len_dlc'(max_data_bytes) : dlc_in;
	assign data_last = cnt_w'({frame_dlc, 3'b000}) - cnt_w'(1);

	// Trailing stuff bit after the last CRC bit lands in the delimiter slot
	assign bits.stuff_active = state inside {st_id_a, st_rtr_srr, st_ide, st_id_b, st_rtr,
		st_reserved1, st_reserved0, st_dlc, st_data, st_crc, st_crc_delim};

	//==============================
	// CRC link
	//==============================
	assign crc_init  = take_bit & (state == st_idle) & ~rx_bit;
	assign crc_shift = take_bit & (state inside {st_id_a, st_rtr_srr, st_ide, st_id_b,
		st_rtr, st_reserved1, st_reserved0, st_dlc, st_data});	// SOF through data
	assign crc_bit   = rx_bit;

	//==============================
	// Next state and error checks
	//==============================
	always_comb
	begin
		state_next = state;
		err_next   = err_none;
		valid_next = 1'b0;
		if (take_bit)
		begin
			if (bits.stuff_error)
				err_next = err_stuff;
			else
			begin
				case (state)
					st_idle:
						if (!rx_bit)
							state_next = st_id_a;	// SOF
					st_id_a:
						if (cnt == cnt_w'(len_id_a - 1))
							state_next = st_rtr_srr;
					st_rtr_srr:
						state_next = st_ide;
					st_ide:
						if (!rx_bit)
							state_next = st_reserved0;	// Base frame, r0 follows
						else if (!frame_rtr)
							err_next = err_form;		// SRR must be recessive
						else
							state_next = st_id_b;
					st_id_b:
						if (cnt == cnt_w'(len_id_b - 1))
							state_next = st_rtr;
					st_rtr:
						state_next = st_reserved1;
					st_reserved1:
						state_next = st_reserved0;
					st_reserved0:
						state_next = st_dlc;
					st_dlc:
						if (cnt == cnt_w'(len_dlc - 1))	// No data field for RTR or DLC 0
							state_next = (frame_rtr || dlc_clip == '0) ? st_crc : st_data;
					st_data:
						if (cnt == data_last)
							state_next = st_crc;
					st_crc:
						if (cnt == cnt_w'(len_crc - 1))
							state_next = st_crc_delim;
					st_crc_delim:
						if (!rx_bit)
							err_next = err_form;
						else
							state_next = st_ack_slot;
					st_ack_slot:
						if (rx_bit)
							err_next = err_ack;	// No receiver drove it
						else
							state_next = st_ack_delim;
					st_ack_delim:
						if (!rx_bit)
							err_next = err_form;
						else if (crc_value != crc_rx)
							err_next = err_crc;	// Checked late, as the spec places it
						else
							state_next = st_eof;
					st_eof:
						if (!rx_bit)
							err_next = err_form;
						else if (cnt == cnt_w'(len_eof - 1))
						begin
							state_next = st_intermission;
							valid_next = 1'b1;
						end
					st_intermission:
						if (!rx_bit)
							err_next = err_form;
						else if (cnt == cnt_w'(len_intermission - 1))
							state_next = st_idle;
					st_error_wait:
						if (rx_bit && cnt == cnt_w'(bus_idle_bits - 1))
							state_next = st_idle;
					default:
						state_next = st_idle;
				endcase
			end
			if (err_next != err_none)
				state_next = st_error_wait;
		end
	end

	//==============================
	// State, counter, pulses
	//==============================
	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			state       <= st_idle;
			cnt         <= '0;
			frame_valid <= 1'b0;
			frame_error <= 1'b0;
			error_kind  <= err_none;
		end
		else
		begin
			frame_valid <= valid_next;
			frame_error <= (err_next != err_none);
			if (err_next != err_none)
				error_kind <= err_next;	// Held until the next error
			state <= state_next;
			if (state_next != state)
				cnt <= '0;
			else if (take_bit && state != st_idle)	// Dominant restarts the idle run
				cnt <= (state == st_error_wait && !rx_bit) ? '0 : cnt + 1'b1;
		end
	end

	// Field capture, destuffed bits only
	always_ff @(posedge clock)
	begin
		if (take_bit)
		begin
			case (state)
				st_idle:
					if (!rx_bit)
					begin
						frame_id   <= '0;
						frame_dlc  <= '0;
						frame_data <= '0;
					end
				st_id_a, st_id_b:
					frame_id <= {frame_id[frame_id_w-2:0], rx_bit};
				st_rtr_srr, st_rtr:
					frame_rtr <= rx_bit;	// SRR overwritten by real RTR
				st_ide:
					frame_ide <= rx_bit;
				st_dlc:
					frame_dlc <= dlc_clip;
				st_data:
					frame_data <= {frame_data[frame_data_w-2:0], rx_bit};
				st_crc:
					crc_rx <= {crc_rx[len_crc-2:0], rx_bit};
				default:
					;
			endcase
		end
	end

endmodule

// ==== hdl/can_frame_pkg.sv ====
package can_frame_pkg;

	// Decoder walks the frame one field per state
	typedef enum logic [4:0] {
		st_idle,
		st_id_a,		// Base identifier
		st_rtr_srr,		// RTR in base frame, SRR in extended
		st_ide,
		st_id_b,		// Extension, extended frames only
		st_rtr,
		st_reserved1,
		st_reserved0,
		st_dlc,
		st_data,
		st_crc,
		st_crc_delim,
		st_ack_slot,
		st_ack_delim,
		st_eof,
		st_intermission,
		st_error_wait	// Waits for a quiet bus
	} decoder_state_t;

	typedef enum logic [2:0] {
		err_none,
		err_stuff,	// Sixth equal bit
		err_form,	// Fixed-form bit dominant
		err_ack,	// Nobody acknowledged
		err_crc		// Sequence mismatch
	} error_kind_t;

	localparam int frame_id_w   = 29;	// Base part in the upper bits when extended
	localparam int frame_data_w = 64;	// Up to eight bytes

endpackage

// ==== sim/can_decoder_chk.sv ====
`timescale 1ns/1ps

module can_decoder_chk (
	input logic                          clock,
	input logic                          reset,
	input logic                          sample,
	input logic                          crc_shift,
	input logic                          frame_valid,
	input logic                          frame_error,
	input can_frame_pkg::decoder_state_t state
);

	int failures = 0;	// Summed into the testbench summary

	//==============================
	// Output pulses
	//==============================
	a_pulse_exclusive: assert property (@(posedge clock) disable iff (reset)
		!(frame_valid && frame_error))
	else
	begin
		failures++;
		$error("frame_valid and frame_error are high in the same cycle");
	end

	a_valid_single: assert property (@(posedge clock) disable iff (reset)
		frame_valid |=> !frame_valid)
	else
	begin
		failures++;
		$error("frame_valid stayed high for more than one cycle");
	end

	a_error_single: assert property (@(posedge clock) disable iff (reset)
		frame_error |=> !frame_error)
	else
	begin
		failures++;
		$error("frame_error stayed high for more than one cycle");
	end

	//==============================
	// Strobe qualification
	//==============================
	// No strobe, no move
	a_state_on_sample: assert property (@(posedge clock) disable iff (reset)
		!sample |=> $stable(state))
	else
	begin
		failures++;
		$error("decoder state changed without a sample strobe");
	end

	a_shift_on_sample: assert property (@(posedge clock) disable iff (reset)
		crc_shift |-> sample)
	else
	begin
		failures++;
		$error("CRC register shifted outside a sample strobe");
	end

endmodule

bind can_frame_fsm can_decoder_chk u_chk (
	.clock       (clock),
	.reset       (reset),
	.sample      (bits.sample),
	.crc_shift   (crc_shift),
	.frame_valid (frame_valid),
	.frame_error (frame_error),
	.state       (state)
);

// ==== sim/can_decoder_tb.sv ====
`timescale 1ns/1ps

module can_decoder_tb;

	import can_bus_pkg::*;
	import can_frame_pkg::*;

	localparam int num_frames   = 16;
	localparam int clk_per_bit  = 4;	// Strobe every fourth clock
	localparam int pulse_margin = 20;	// Extra bits allowed for a pulse
	localparam int idle_after   = 12;	// Recessive bits after an error frame

	logic clock;
	logic reset;
	logic rx_bit;
	logic sample_point;
	logic frame_valid;
	logic frame_error;
	error_kind_t error_kind;
	logic [frame_id_w-1:0] frame_id;
	logic frame_ide;
	logic frame_rtr;
	logic [len_dlc-1:0] frame_dlc;
	logic [frame_data_w-1:0] frame_data;

	int seed = 73;
	int value_errors = 0;
	int pulse_errors = 0;
	int valid_seen = 0;

	logic raw_bits[$];		// SOF through CRC, unstuffed
	logic tx_bits[$];		// Whole frame as it goes on the wire
	logic [7:0] tx_bytes[8];

	// Expected capture
	logic [frame_id_w-1:0]   exp_id;
	logic                    exp_ide;
	logic                    exp_rtr;
	logic [len_dlc-1:0]      exp_dlc;
	logic [frame_data_w-1:0] exp_data;

	tb_clock_gen #(.reset_cycles(8)) u_clock (.clock(clock), .reset(reset));

	can_decoder #(
		.bus_idle_bits (11)
	) u_dut (
		.clock        (clock),
		.reset        (reset),
		.rx_bit       (rx_bit),
		.sample_point (sample_point),
		.frame_valid  (frame_valid),
		.frame_error  (frame_error),
		.error_kind   (error_kind),
		.frame_id     (frame_id),
		.frame_ide    (frame_ide),
		.frame_rtr    (frame_rtr),
		.frame_dlc    (frame_dlc),
		.frame_data   (frame_data)
	);

	always @(posedge clock)
	begin
		if (frame_valid)
			valid_seen <= valid_seen + 1;	// Catches stray pulses too
	end

	task automatic check_value(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		assert (actual === expected)
		else
		begin
			$display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
			value_errors++;
		end
	endtask

	//==============================
	// Frame assembly
	//==============================
	task automatic push_field(input logic [31:0] value, input int width);
		for (int i = width - 1; i >= 0; i--)
			raw_bits.push_back(value[i]);	// MSB first
	endtask

	// CAN CRC-15, register MSB against the incoming bit
	function automatic logic [len_crc-1:0] crc15_of();
		logic [len_crc-1:0] crc;
		logic fb;
		crc = '0;
		foreach (raw_bits[i])
		begin
			fb  = raw_bits[i] ^ crc[len_crc-1];
			crc = {crc[len_crc-2:0], 1'b0};
			if (fb)
				crc = crc ^ crc_poly;
		end
		return crc;
	endfunction

	task automatic build_frame(input logic [28:0] id, input logic ide, input logic rtr,
		input logic [3:0] dlc, input int crc_flip, input logic stuff_en, input logic ack_bit);
		int nbytes;
		int run;
		logic last;
		logic [len_crc-1:0] crc;
		raw_bits.delete();
		tx_bits.delete();
		nbytes = rtr ? 0 : ((dlc > 4'd8) ? max_data_bytes : int'(dlc));	// RTR carries no data
		raw_bits.push_back(1'b0);	// SOF
		if (ide)
		begin
			push_field(32'(id[28:18]), len_id_a);
			push_field(32'b11, 2);	// SRR, IDE
			push_field(32'(id[17:0]), len_id_b);
			push_field(32'({rtr, 2'b00}), 3);	// RTR, r1, r0
		end
		else
		begin
			push_field(32'(id[10:0]), len_id_a);
			push_field(32'({rtr, 2'b00}), 3);	// RTR, IDE, r0
		end
		push_field(32'(dlc), len_dlc);
		for (int b = 0; b < nbytes; b++)
			push_field(32'(tx_bytes[b]), 8);
		crc = crc15_of();
		if (crc_flip >= 0)
			crc[crc_flip] = ~crc[crc_flip];	// Corrupt before stuffing
		push_field(32'(crc), len_crc);

		// Stuffing from SOF to the last CRC bit
		run  = 0;
		last = 1'b1;
		foreach (raw_bits[i])
		begin
			tx_bits.push_back(raw_bits[i]);
			run  = (raw_bits[i] == last) ? run + 1 : 1;
			last = raw_bits[i];
			if (stuff_en && run == stuff_run)
			begin
				tx_bits.push_back(~last);
				last = ~last;
				run  = 1;
			end
		end
		tx_bits.push_back(1'b1);	// CRC delimiter
		tx_bits.push_back(ack_bit);
		repeat (1 + len_eof + len_intermission)
			tx_bits.push_back(1'b1);	// ACK delimiter, EOF, intermission

		exp_id   = ide ? id : {18'b0, id[10:0]};
		exp_ide  = ide;
		exp_rtr  = rtr;
		exp_dlc  = (dlc > 4'd8) ? 4'd8 : dlc;
		exp_data = '0;
		for (int b = 0; b < nbytes; b++)
			exp_data = {exp_data[frame_data_w-9:0], tx_bytes[b]};	// First byte ends up highest
	endtask

	//==============================
	// Bus driving
	//==============================
	task automatic send_bit(input logic value);
		@(posedge clock);
		rx_bit       <= value;
		sample_point <= 1'b1;
		@(posedge clock);
		sample_point <= 1'b0;
		repeat (clk_per_bit - 2) @(posedge clock);
	endtask

	task automatic send_idle(input int count);
		repeat (count) send_bit(1'b1);
	endtask

	task automatic wait_pulse(input int limit_bits, output logic got_valid,
		output logic got_error);
		int cycles;
		got_valid = 1'b0;
		got_error = 1'b0;
		cycles    = 0;
		while (!got_valid && !got_error && cycles < limit_bits * clk_per_bit)
		begin
			@(posedge clock);
			got_valid = frame_valid;
			got_error = frame_error;
			cycles++;
		end
	endtask

	// Drives the built frame, then checks fields or the error kind
	task automatic run_frame(input logic expect_valid, input error_kind_t expect_kind);
		logic got_valid;
		logic got_error;
		int valid_before;
		valid_before = valid_seen;
		fork
			foreach (tx_bits[i])
				send_bit(tx_bits[i]);
			wait_pulse(tx_bits.size() + pulse_margin, got_valid, got_error);
		join
		if (!got_valid && !got_error)
		begin
			$display("No frame_valid or frame_error pulse within %0d bits, frame ending at %0t",
				tx_bits.size() + pulse_margin, $time);
			pulse_errors++;
		end
		else if (expect_valid)
		begin
			check_value("frame_valid", 64'd1, 64'(got_valid));
			check_value("frame_id", 64'(exp_id), 64'(frame_id));
			check_value("frame_ide", 64'(exp_ide), 64'(frame_ide));
			check_value("frame_rtr", 64'(exp_rtr), 64'(frame_rtr));
			check_value("frame_dlc", 64'(exp_dlc), 64'(frame_dlc));
			check_value("frame_data", exp_data, frame_data);
		end
		else
		begin
			send_idle(idle_after);	// Lets the decoder leave error_wait
			check_value("frame_error", 64'd1, 64'(got_error));
			check_value("error_kind", 64'(expect_kind), 64'(error_kind));
			check_value("frame_valid count", 64'(valid_before), 64'(valid_seen));
		end
	endtask

	task automatic fill_bytes();
		logic [31:0] r;
		for (int i = 0; i < 8; i++)
		begin
			r = $random(seed);
			tx_bytes[i] = r[7:0];
		end
	endtask

	task automatic send_data_frame(input logic ide);
		logic [31:0] r;
		logic [31:0] id;
		r  = $random(seed);
		id = $random(seed);
		fill_bytes();
		build_frame(id[28:0], ide, 1'b0, 4'(r[2:0]) + 4'd1, -1, 1'b1, 1'b0);	// DLC 1 to 8
		run_frame(1'b1, err_none);
	endtask

	//==============================
	// Test sequence
	//==============================
	initial
	begin
		logic [31:0] r;
		rx_bit       <= 1'b1;
		sample_point <= 1'b0;
		wait (reset === 1'b0);
		send_idle(idle_after);

		repeat (3) send_data_frame(1'b0);
		repeat (2) send_data_frame(1'b1);	// Extended

		r = $random(seed);
		build_frame(r[28:0], 1'b0, 1'b1, r[15:12], -1, 1'b1, 1'b0);	// RTR
		run_frame(1'b1, err_none);
		r = $random(seed);
		build_frame(r[28:0], 1'b0, 1'b0, 4'd0, -1, 1'b1, 1'b0);	// Empty data field
		run_frame(1'b1, err_none);
		fill_bytes();
		build_frame(r[31:3], 1'b0, 1'b0, 4'd12, -1, 1'b1, 1'b0);	// Clipped to eight bytes
		run_frame(1'b1, err_none);

		// Each error frame followed by a clean one
		r = $random(seed);
		build_frame(r[28:0], 1'b0, 1'b0, 4'd2, int'(r[19:16]) % len_crc, 1'b1, 1'b0);
		run_frame(1'b0, err_crc);
		send_data_frame(1'b0);
		build_frame(29'd0, 1'b0, 1'b0, 4'd0, -1, 1'b0, 1'b0);	// All dominant up to the delimiter
		run_frame(1'b0, err_stuff);
		send_data_frame(1'b0);
		build_frame(r[28:0], 1'b0, 1'b0, 4'd3, -1, 1'b1, 1'b1);	// Recessive ACK slot
		run_frame(1'b0, err_ack);
		send_data_frame(1'b0);

		// Back to back, intermission only
		send_data_frame(1'b0);
		send_data_frame(1'b0);

		$display("Errors: %0d value mismatches, %0d missing pulses, %0d assertion failures",
			value_errors, pulse_errors, u_dut.u_fsm.u_chk.failures);
		if (value_errors == 0 && pulse_errors == 0 && u_dut.u_fsm.u_chk.failures == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

	// Watchdog, 160 bits of 40 ns per frame
	initial
	begin
		#(num_frames * 160 * 40);
		$display("Watchdog expired, the run did not finish within %0d frame slots", num_frames);
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

// ==== sim/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int reset_cycles = 8
) (
	output logic clock,
	output logic reset
);

	// 10 ns period
	initial
	begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	initial
	begin
		reset <= 1'b1;
		repeat (reset_cycles) @(posedge clock);
		reset <= 1'b0;	// Released on an edge
	end

endmodule

// ==== verilog.f ====
hdl/can_bus_pkg.sv
hdl/can_frame_pkg.sv
hdl/can_bit_if.sv
hdl/can_destuffer.sv
hdl/can_crc15.sv
hdl/can_frame_fsm.sv
hdl/can_decoder.sv
sim/tb_clock_gen.sv
sim/can_decoder_chk.sv
sim/can_decoder_tb.sv
